//--- Bender.yml
package:
  name: exec_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_isa_pkg.sv
      - verilog/exu_pipe_pkg.sv
      - verilog/inst_decode.sv
      - verilog/reg_file.sv
      - verilog/alu.sv
      - verilog/exu.sv
      - verilog/exec_core_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/exec_core_chk.sv
      - test/exec_core_tb.sv

//--- list.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/exu_pipe_pkg.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/exu.sv
verilog/exec_core_top.sv
test/exec_core_chk.sv
test/exec_core_tb.sv

//--- test/exec_core_chk.sv
`timescale 1ns/10ps
`include "exu_defs.svh"

module exec_core_chk (
	input logic clock,
	input logic reset,
	input logic exu_valid,
	input logic exu_ready,
	input exu_pipe_pkg::commit_t commit,
	input exu_pipe_pkg::redirect_t redirect,
	input exu_pipe_pkg::btb_update_t btb_update,
	input exu_pipe_pkg::mem_req_t mem_req
);
	import exu_pipe_pkg::*;

	logic pulses;
	int failures = 0;

	assign pulses = commit.reg_wen | redirect.jump_wrong | btb_update.wvalid
		| mem_req.ren | mem_req.wen;

	pulse_after_accept: assert property (@(posedge clock) disable iff (reset)
		!(exu_valid && exu_ready) |=> !pulses)
		else begin
			$error("pulse output high in a cycle not preceded by an accept");
			failures++;
		end

	btb_needs_redirect: assert property (@(posedge clock) disable iff (reset)
		btb_update.wvalid |-> redirect.jump_wrong)
		else begin
			$error("btb update without a redirect");
			failures++;
		end

	mem_one_strobe: assert property (@(posedge clock) disable iff (reset)
		!(mem_req.ren && mem_req.wen))
		else begin
			$error("read and write strobes high together");
			failures++;
		end

endmodule

bind exu exec_core_chk u_chk (
	.clock      (clock),
	.reset      (reset),
	.exu_valid  (exu_valid),
	.exu_ready  (exu_ready),
	.commit     (commit),
	.redirect   (redirect),
	.btb_update (btb_update),
	.mem_req    (mem_req)
);

//--- test/exec_core_tb.sv
`timescale 1ns/10ps

module exec_core_tb;
	import rv_isa_pkg::*;
	import exu_pipe_pkg::*;

	typedef struct packed {
		fetch_bundle_t f;
		logic wen;
		logic [3:0] rd;
		logic [31:0] val;
		logic jmp;
		logic [31:0] tgt;
		logic btb; // jal or backward branch
		logic fencei;
		logic ren;
		logic wenm;
		logic [31:0] addr;
		logic [31:0] wdata;
	} expect_t;

	logic clock;
	logic reset;
	logic fetch_valid;
	logic exu_ready;
	fetch_bundle_t fetch;
	commit_t commit;
	redirect_t redirect;
	btb_update_t btb_update;
	mem_req_t mem_req;

	expect_t seq[$];
	logic [31:0] shadow [16];
	logic [31:0] pc_cur;
	string test_name;
	int test_checks;
	int test_errors;
	int checks = 0;
	int errors = 0;
	int cycles = 0;

	exec_core_top DUT (
		.clock      (clock),
		.reset      (reset),
		.fetch      (fetch),
		.fetch_valid(fetch_valid),
		.exu_ready  (exu_ready),
		.commit     (commit),
		.redirect   (redirect),
		.btb_update (btb_update),
		.mem_req    (mem_req)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= 2000) begin
			$display("timeout: the run did not finish within 2000 cycles");
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm[11:0], rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm20, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm20, rd, opc};
	endfunction

	function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// next instruction slot, fall-through predicted
	function automatic expect_t blank(input logic [31:0] inst);
		expect_t e;
		e = '0;
		e.f.inst = inst;
		e.f.pc = pc_cur;
		e.f.dnpc = pc_cur + 4;
		pc_cur = pc_cur + 4;
		return e;
	endfunction

	task automatic push_wr(input logic [31:0] inst, input logic [3:0] rd, input logic [31:0] val);
		expect_t e;
		e = blank(inst);
		e.wen = 1'b1;
		e.rd = rd;
		e.val = val;
		seq.push_back(e);
		if (rd != 0)
			shadow[rd] = val;
	endtask

	task automatic load_reg(input logic [3:0] r, input logic [31:0] v);
		logic [31:0] hi;
		hi = v - {{20{v[11]}}, v[11:0]};
		push_wr(enc_u(hi[31:12], r, OPC_LUI), r, hi);
		push_wr(enc_i(v, r, 3'd0, r, OPC_OPIMM), r, v); // reads the lui result next cycle
	endtask

	task automatic push_jump(input logic [31:0] inst, input logic [3:0] rd,
		input logic [31:0] tgt, input logic btb, input logic good);
		expect_t e;
		e = blank(inst);
		e.wen = 1'b1;
		e.rd = rd;
		e.val = e.f.pc + 4;
		e.jmp = 1'b1;
		e.tgt = tgt;
		e.btb = btb;
		if (good)
			e.f.dnpc = tgt;
		seq.push_back(e);
		shadow[rd] = e.val;
	endtask

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		test_checks++;
		if (exp !== act) begin
			$display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_out(input expect_t e);
		logic [31:0] ja;
		logic jw;
		ja = e.jmp ? e.tgt : e.f.pc + 4;
		jw = (ja != e.f.dnpc) | e.fencei;
		check("reg_wen", e.wen, commit.reg_wen);
		if (e.wen) begin
			check("rd", e.rd, commit.rd);
			check("val", e.val, commit.val);
		end
		check("jump_wrong", jw, redirect.jump_wrong);
		check("jump_addr", ja, redirect.jump_addr);
		check("btb wvalid", jw & e.btb, btb_update.wvalid);
		if (jw & e.btb) begin
			check("btb pc", e.f.pc[24:0], btb_update.pc);
			check("btb target", ja, btb_update.target);
		end
		check("ren", e.ren, mem_req.ren);
		check("wen", e.wenm, mem_req.wen);
		if (e.ren | e.wenm)
			check("addr", e.addr, mem_req.addr);
		if (e.wenm)
			check("wdata", e.wdata, mem_req.wdata);
	endtask

	// issue the queue back to back, result of slot i-1 is seen while slot i is driven
	task automatic run_seq();
		int n;
		n = seq.size();
		for (int i = 0; i <= n; i++) begin
			@(posedge clock);
			if (i < n) begin
				fetch <= seq[i].f;
				fetch_valid <= 1'b1;
				exu_ready <= 1'b1;
			end else begin
				fetch_valid <= 1'b0;
			end
			@(negedge clock);
			if (i > 0)
				check_out(seq[i-1]);
		end
		seq.delete();
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test();
		$display("%s: %0d checks, %0d errors", test_name, test_checks, test_errors);
		checks += test_checks;
		errors += test_errors;
	endtask

	task automatic test_alu();
		logic [31:0] a;
		logic [31:0] b;
		start_test("alu");
		a = $urandom | 32'h8000_0000; // negative for sra
		b = $urandom;
		load_reg(1, a);
		load_reg(2, b);
		push_wr(enc_r(7'h00, 2, 1, 3'd0, 3), 3, a + b);
		push_wr(enc_r(7'h20, 2, 3, 3'd0, 4), 4, shadow[3] - b);
		push_wr(enc_r(7'h00, 2, 1, 3'd7, 5), 5, a & b);
		push_wr(enc_r(7'h00, 2, 1, 3'd6, 6), 6, a | b);
		push_wr(enc_r(7'h00, 2, 1, 3'd4, 7), 7, a ^ b);
		push_wr(enc_r(7'h00, 2, 1, 3'd1, 8), 8, a << b[4:0]);
		push_wr(enc_r(7'h00, 2, 1, 3'd5, 9), 9, a >> b[4:0]);
		push_wr(enc_r(7'h20, 2, 1, 3'd5, 10), 10, $signed(a) >>> b[4:0]);
		push_wr(enc_r(7'h00, 2, 1, 3'd2, 11), 11, ($signed(a) < $signed(b)) ? 1 : 0);
		push_wr(enc_r(7'h00, 2, 1, 3'd3, 12), 12, (a < b) ? 1 : 0);
		push_wr(enc_i(-5, 4, 3'd0, 13, OPC_OPIMM), 13, shadow[4] - 5);
		push_wr(enc_i(32'h407, 1, 3'd5, 14, OPC_OPIMM), 14, $signed(a) >>> 7);
		push_wr(enc_i(-1, 2, 3'd2, 15, OPC_OPIMM), 15, ($signed(b) < -1) ? 1 : 0);
		run_seq();
		end_test();
	endtask

	task automatic test_upper();
		start_test("upper");
		push_wr(enc_u(20'hABCDE, 5, OPC_LUI), 5, 32'hABCD_E000);
		push_wr(enc_u(20'h00012, 6, OPC_AUIPC), 6, pc_cur + 32'h12000);
		push_wr(enc_u(20'h12345, 0, OPC_LUI), 0, 32'h1234_5000);
		push_wr(enc_r(7'h00, 0, 5, 3'd0, 7), 7, shadow[5]); // x0 still zero
		push_wr(enc_i(32'h55, 0, 3'd0, 8, OPC_OPIMM), 8, 32'h55);
		run_seq();
		end_test();
	endtask

	task automatic test_branch();
		logic [2:0] conds [6];
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] off;
		expect_t e;
		conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		start_test("branch");
		a = $urandom >> 2;
		b = a + ($urandom >> 2) + 1; // above a, signed and unsigned
		load_reg(1, a);
		load_reg(2, b);
		push_wr(enc_i(0, 1, 3'd0, 3, OPC_OPIMM), 3, a);
		for (int c = 0; c < 6; c++) begin
			for (int k = 0; k < 2; k++) begin
				for (int w = 0; w < 2; w++) begin
					off = k ? -16 : 24;
					e = blank(enc_b(off, k ? 3 : 2, 1, conds[c]));
					e.jmp = branch_taken(conds[c], a, shadow[k ? 3 : 2]);
					e.tgt = e.f.pc + off;
					e.btb = k;
					if (w)
						e.f.dnpc = e.jmp ? e.f.pc + 4 : e.tgt; // mispredicted
					else
						e.f.dnpc = e.jmp ? e.tgt : e.f.pc + 4;
					seq.push_back(e);
				end
			end
		end
		run_seq();
		end_test();
	endtask

	task automatic test_jump();
		expect_t e;
		start_test("jump");
		load_reg(5, 32'h0000_1000);
		push_jump(enc_j(-8, 1), 1, pc_cur - 8, 1'b1, 1'b0);
		push_jump(enc_j(40, 2), 2, pc_cur + 40, 1'b1, 1'b1);
		push_jump(enc_i(12, 5, 3'd0, 3, OPC_JALR), 3, shadow[5] + 12, 1'b0, 1'b1);
		push_jump(enc_i(-4, 5, 3'd0, 4, OPC_JALR), 4, shadow[5] - 4, 1'b0, 1'b0);
		e = blank(enc_i(0, 0, 3'd1, 0, OPC_MISCMEM));
		e.fencei = 1'b1;
		seq.push_back(e);
		run_seq();
		end_test();
	endtask

	task automatic test_mem();
		logic [31:0] base;
		logic [31:0] data;
		expect_t e;
		start_test("mem");
		base = $urandom & 32'h0FFF_FFFC;
		data = $urandom;
		load_reg(8, base);
		load_reg(9, data);
		e = blank(enc_i(20, 8, 3'd2, 10, OPC_LOAD));
		e.ren = 1'b1;
		e.addr = base + 20;
		seq.push_back(e);
		e = blank(enc_s(-12, 9, 8));
		e.wenm = 1'b1;
		e.addr = base - 12;
		e.wdata = data;
		seq.push_back(e);
		run_seq();
		end_test();
	endtask

	task automatic check_quiet(input string when);
		check({when, " reg_wen"}, 0, commit.reg_wen);
		check({when, " jump_wrong"}, 0, redirect.jump_wrong);
		check({when, " btb wvalid"}, 0, btb_update.wvalid);
		check({when, " ren"}, 0, mem_req.ren);
		check({when, " wen"}, 0, mem_req.wen);
	endtask

	task automatic test_backpressure();
		expect_t e;
		start_test("backpressure");
		push_wr(enc_i(77, 0, 3'd0, 11, OPC_OPIMM), 11, 77);
		run_seq();
		e = blank(enc_i(5, 11, 3'd0, 12, OPC_OPIMM));
		@(posedge clock);
		fetch <= e.f;
		fetch_valid <= 1'b1;
		exu_ready <= 1'b0;
		repeat (4) begin
			@(negedge clock);
			check_quiet("stalled");
			check("held rd", 11, commit.rd);
			check("held val", 77, commit.val);
		end
		@(posedge clock);
		exu_ready <= 1'b1;
		@(posedge clock);
		fetch_valid <= 1'b0;
		@(negedge clock);
		check("released reg_wen", 1, commit.reg_wen);
		check("released rd", 12, commit.rd);
		check("released val", 82, commit.val);
		@(posedge clock);
		fetch_valid <= 1'b1;
		reset <= 1'b1;
		@(posedge clock);
		@(posedge clock);
		reset <= 1'b0;
		fetch_valid <= 1'b0;
		@(negedge clock);
		check_quiet("after reset");
		@(negedge clock);
		check_quiet("after reset");
		end_test();
	endtask

	initial begin
		void'($urandom(10));
		reset = 1'b1;
		fetch = '0;
		fetch_valid = 1'b0;
		exu_ready = 1'b0;
		pc_cur = 32'h0000_0100;
		for (int i = 0; i < 16; i++)
			shadow[i] = '0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		test_alu();
		test_upper();
		test_branch();
		test_jump();
		test_mem();
		test_backpressure();
		if (DUT.u_exu.u_chk.failures != 0)
			$display("exu checker: %0d assertion failures", DUT.u_exu.u_chk.failures);
		errors += DUT.u_exu.u_chk.failures;
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- verilog/alu.sv
`timescale 1ns/10ps
`include "exu_defs.svh"

module alu (
	input  logic [rv_isa_pkg::INST_CLASSES-1:0] opcode_type,
	input  logic [2:0] funct3,
	input  logic funct7_5,
	input  logic [`XLEN-1:0] src1,
	input  logic [`XLEN-1:0] src2,
	input  logic [`XLEN-1:0] imm,
	input  logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] alu_val,
	output logic [`XLEN-1:0] sum
);
	import rv_isa_pkg::*;
	import exu_pipe_pkg::*;

	logic [`XLEN-1:0] lop;
	logic [`XLEN-1:0] rop;
	logic [`XLEN-1:0] diff;
	logic borrow;
	logic less;
	logic [2*`XLEN-2:0] sra_ext;
	alu_op_t op;

	assign lop = (opcode_type[INST_AUIPC] | opcode_type[INST_JAL] | opcode_type[INST_BEQ]) ? pc :
		opcode_type[INST_LUI] ? '0 : src1;
	assign rop = opcode_type[INST_ADD] ? src2 : imm;

	always_comb begin
		op = OP_ADD; // address and upper-imm classes
		if (opcode_type[INST_ADDI] | opcode_type[INST_ADD]) begin
			case (funct3)
				3'b000: op = (opcode_type[INST_ADD] & funct7_5) ? OP_SUB : OP_ADD;
				3'b001: op = OP_SLL;
				3'b010: op = OP_LESS;
				3'b011: op = OP_ULESS;
				3'b100: op = OP_XOR;
				3'b101: op = funct7_5 ? OP_SRA : OP_SRL;
				3'b110: op = OP_OR;
				default: op = OP_AND;
			endcase
		end
	end

	assign sum = lop + rop;
	assign {borrow, diff} = {1'b0, lop} - {1'b0, rop};
	assign less = (lop[`XLEN-1] & ~rop[`XLEN-1]) | (~(lop[`XLEN-1] ^ rop[`XLEN-1]) & diff[`XLEN-1]);
	assign sra_ext = {{(`XLEN-1){lop[`XLEN-1]}}, lop} >> rop[4:0];

	always_comb begin
		case (op)
			OP_SUB:   alu_val = diff;
			OP_AND:   alu_val = lop & rop;
			OP_XOR:   alu_val = lop ^ rop;
			OP_OR:    alu_val = lop | rop;
			OP_SRL:   alu_val = lop >> rop[4:0];
			OP_SRA:   alu_val = sra_ext[`XLEN-1:0];
			OP_SLL:   alu_val = lop << rop[4:0];
			OP_LESS:  alu_val = {{(`XLEN-1){1'b0}}, less};
			OP_ULESS: alu_val = {{(`XLEN-1){1'b0}}, borrow};
			default:  alu_val = sum;
		endcase
	end

endmodule

//--- verilog/exec_core_top.sv
`timescale 1ns/10ps
`include "exu_defs.svh"

module exec_core_top (
	input  logic clock,
	input  logic reset,
	input  exu_pipe_pkg::fetch_bundle_t fetch,
	input  logic fetch_valid,
	input  logic exu_ready,
	output exu_pipe_pkg::commit_t commit,
	output exu_pipe_pkg::redirect_t redirect,
	output exu_pipe_pkg::btb_update_t btb_update,
	output exu_pipe_pkg::mem_req_t mem_req
);
	import exu_pipe_pkg::*;

	logic [`REG_ADDR_W-1:0] rs1_addr;
	logic [`REG_ADDR_W-1:0] rs2_addr;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	issue_bundle_t issue;

	inst_decode u_decode (
		.fetch    (fetch),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.issue    (issue)
	);

	reg_file u_regs (
		.clock    (clock),
		.reset    (reset),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.commit   (commit),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	exu u_exu (
		.clock      (clock),
		.reset      (reset),
		.issue      (issue),
		.exu_valid  (fetch_valid),
		.exu_ready  (exu_ready),
		.commit     (commit),
		.redirect   (redirect),
		.btb_update (btb_update),
		.mem_req    (mem_req)
	);

endmodule

//--- verilog/exu.sv
`timescale 1ns/10ps
`include "exu_defs.svh"

module exu (
	input  logic clock,
	input  logic reset,
	input  exu_pipe_pkg::issue_bundle_t issue,
	input  logic exu_valid,
	input  logic exu_ready,
	output exu_pipe_pkg::commit_t commit,
	output exu_pipe_pkg::redirect_t redirect,
	output exu_pipe_pkg::btb_update_t btb_update,
	output exu_pipe_pkg::mem_req_t mem_req
);
	import rv_isa_pkg::*;
	import exu_pipe_pkg::*;

	logic accept;
	logic [`XLEN-1:0] alu_val;
	logic [`XLEN-1:0] sum;
	logic [`XLEN-1:0] snpc;
	logic [`XLEN-1:0] compare;
	logic [`XLEN-1:0] jump_addr;
	logic [`XLEN-1:0] wb_val;
	logic borrow;
	logic less;
	logic jump_cond;
	logic jump_en;
	logic jump_wrong;
	logic need_btb;
	logic link;

	alu u_alu (
		.opcode_type (issue.opcode_type),
		.funct3      (issue.funct3),
		.funct7_5    (issue.funct7_5),
		.src1        (issue.src1),
		.src2        (issue.src2),
		.imm         (issue.imm),
		.pc          (issue.pc),
		.alu_val     (alu_val),
		.sum         (sum)
	);

	assign accept = exu_valid & exu_ready;
	assign snpc = issue.pc + `XLEN'd4;
	assign link = issue.opcode_type[INST_JAL] | issue.opcode_type[INST_JALR];

	// branch compare on the register operands
	assign {borrow, compare} = {1'b0, issue.src1} - {1'b0, issue.src2};
	assign less = (issue.src1[`XLEN-1] & ~issue.src2[`XLEN-1])
		| (~(issue.src1[`XLEN-1] ^ issue.src2[`XLEN-1]) & compare[`XLEN-1]);

	always_comb begin
		case (issue.funct3)
			3'b000:  jump_cond = ~|compare; // beq
			3'b001:  jump_cond = |compare;
			3'b100:  jump_cond = less;
			3'b101:  jump_cond = ~less;
			3'b110:  jump_cond = borrow; // bltu
			3'b111:  jump_cond = ~borrow;
			default: jump_cond = 1'b0;
		endcase
	end

	assign jump_en = link | (issue.opcode_type[INST_BEQ] & jump_cond);
	assign jump_addr = jump_en ? sum : snpc;
	assign jump_wrong = (jump_addr != issue.dnpc) | issue.inst_fencei;
	assign need_btb = issue.opcode_type[INST_JAL] | (issue.opcode_type[INST_BEQ] & issue.imm[`XLEN-1]);
	assign wb_val = link ? snpc : alu_val;

	always_ff @(posedge clock) begin
		if (reset) begin
			commit.reg_wen <= 1'b0;
			redirect.jump_wrong <= 1'b0;
			btb_update.wvalid <= 1'b0;
			mem_req.ren <= 1'b0;
			mem_req.wen <= 1'b0;
		end else begin
			// pulses last one cycle after each accept
			commit.reg_wen <= accept & issue.reg_wen;
			redirect.jump_wrong <= accept & jump_wrong;
			btb_update.wvalid <= accept & jump_wrong & need_btb;
			mem_req.ren <= accept & issue.opcode_type[INST_LW];
			mem_req.wen <= accept & issue.opcode_type[INST_SW];
		end
		if (accept) begin
			commit.rd <= issue.rd;
			commit.val <= wb_val;
			redirect.jump_addr <= jump_addr;
			btb_update.pc <= issue.pc[`BTB_PC_W-1:0];
			btb_update.target <= jump_addr;
			mem_req.addr <= sum;
			mem_req.wdata <= issue.src2;
		end
	end

endmodule

//--- verilog/exu_defs.svh
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// datapath and address width
`define XLEN 32

// rv32e register file
`define NUM_REGS 16
`define REG_ADDR_W 4

// pc bits kept by the btb
`define BTB_PC_W 25

`endif

//--- verilog/exu_pipe_pkg.sv
`include "exu_defs.svh"

package exu_pipe_pkg;

	typedef enum logic [3:0] {
		OP_ADD   = 4'd0,
		OP_SUB   = 4'd1,
		OP_AND   = 4'd2,
		OP_XOR   = 4'd3,
		OP_OR    = 4'd4,
		OP_SRL   = 4'd5,
		OP_SRA   = 4'd6,
		OP_SLL   = 4'd7,
		OP_LESS  = 4'd8,
		OP_ULESS = 4'd9
	} alu_op_t;

	typedef struct packed {
		logic [`XLEN-1:0] inst;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] dnpc; // predicted next pc
	} fetch_bundle_t;

	typedef struct packed {
		logic [rv_isa_pkg::INST_CLASSES-1:0] opcode_type;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0] src1;
		logic [`XLEN-1:0] src2;
		logic [`XLEN-1:0] imm;
		logic [2:0] funct3;
		logic funct7_5;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] dnpc;
		logic reg_wen;
		logic inst_fencei;
	} issue_bundle_t;

	typedef struct packed {
		logic [`REG_ADDR_W-1:0] rd;
		logic reg_wen;
		logic [`XLEN-1:0] val;
	} commit_t;

	typedef struct packed {
		logic jump_wrong;
		logic [`XLEN-1:0] jump_addr;
	} redirect_t;

	typedef struct packed {
		logic wvalid;
		logic [`BTB_PC_W-1:0] pc;
		logic [`XLEN-1:0] target;
	} btb_update_t;

	typedef struct packed {
		logic ren;
		logic wen;
		logic [`XLEN-1:0] addr;
		logic [`XLEN-1:0] wdata;
	} mem_req_t;

endpackage

//--- verilog/inst_decode.sv
`timescale 1ns/10ps
`include "exu_defs.svh"

module inst_decode (
	input  exu_pipe_pkg::fetch_bundle_t fetch,
	input  logic [`XLEN-1:0] rs1_data,
	input  logic [`XLEN-1:0] rs2_data,
	output logic [`REG_ADDR_W-1:0] rs1_addr,
	output logic [`REG_ADDR_W-1:0] rs2_addr,
	output exu_pipe_pkg::issue_bundle_t issue
);
	import rv_isa_pkg::*;
	import exu_pipe_pkg::*;

	inst_word_u word;
	logic [INST_CLASSES-1:0] cls;
	logic [`XLEN-1:0] imm;

	assign word = fetch.inst;
	assign rs1_addr = word.r_fmt.rs1[`REG_ADDR_W-1:0]; // rv32e uses low 4 bits
	assign rs2_addr = word.r_fmt.rs2[`REG_ADDR_W-1:0];

	always_comb begin
		cls = '0;
		imm = '0;
		case (word.r_fmt.opcode)
			OPC_LUI, OPC_AUIPC: begin
				cls[INST_LUI]   = (word.r_fmt.opcode == OPC_LUI);
				cls[INST_AUIPC] = (word.r_fmt.opcode == OPC_AUIPC);
				imm = {word.u_fmt.imm20, 12'b0};
			end
			OPC_JAL: begin
				cls[INST_JAL] = 1'b1;
				imm = {{11{word.u_fmt.imm20[19]}}, word.u_fmt.imm20[19],
					word.u_fmt.imm20[7:0], word.u_fmt.imm20[8],
					word.u_fmt.imm20[18:9], 1'b0};
			end
			OPC_BRANCH: begin
				cls[INST_BEQ] = 1'b1;
				imm = {{19{word.s_fmt.imm_hi[6]}}, word.s_fmt.imm_hi[6],
					word.s_fmt.imm_lo[0], word.s_fmt.imm_hi[5:0],
					word.s_fmt.imm_lo[4:1], 1'b0};
			end
			OPC_STORE: begin
				cls[INST_SW] = 1'b1;
				imm = {{20{word.s_fmt.imm_hi[6]}}, word.s_fmt.imm_hi, word.s_fmt.imm_lo};
			end
			OPC_JALR, OPC_LOAD, OPC_OPIMM: begin
				cls[INST_JALR] = (word.r_fmt.opcode == OPC_JALR);
				cls[INST_LW]   = (word.r_fmt.opcode == OPC_LOAD);
				cls[INST_ADDI] = (word.r_fmt.opcode == OPC_OPIMM);
				imm = {{20{word.i_fmt.imm12[11]}}, word.i_fmt.imm12};
			end
			OPC_OP: cls[INST_ADD] = 1'b1;
			default: ; // unknown or misc-mem, no class
		endcase
	end

	always_comb begin
		issue.opcode_type = cls;
		issue.rd = word.r_fmt.rd[`REG_ADDR_W-1:0];
		issue.src1 = rs1_data;
		issue.src2 = rs2_data;
		issue.imm = imm;
		issue.funct3 = word.r_fmt.funct3;
		issue.funct7_5 = word.r_fmt.funct7[5];
		issue.pc = fetch.pc;
		issue.dnpc = fetch.dnpc;
		// load data is written back by the lsu
		issue.reg_wen = cls[INST_LUI] | cls[INST_AUIPC] | cls[INST_JAL] | cls[INST_JALR]
			| cls[INST_ADDI] | cls[INST_ADD];
		issue.inst_fencei = (word.r_fmt.opcode == OPC_MISCMEM) && (word.r_fmt.funct3 == 3'b001);
	end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/10ps
`include "exu_defs.svh"

module reg_file (
	input  logic clock,
	input  logic reset,
	input  logic [`REG_ADDR_W-1:0] rs1_addr,
	input  logic [`REG_ADDR_W-1:0] rs2_addr,
	input  exu_pipe_pkg::commit_t commit,
	output logic [`XLEN-1:0] rs1_data,
	output logic [`XLEN-1:0] rs2_data
);
	import exu_pipe_pkg::*;

	logic [`XLEN-1:0] regs [1:`NUM_REGS-1]; // x0 not stored
	logic wr_en;

	assign wr_en = commit.reg_wen && (commit.rd != '0);

	function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wr_en && (commit.rd == addr))
			return commit.val; // write-through
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[commit.rd] <= commit.val;
		end
	end

	assign rs1_data = read_port(rs1_addr);
	assign rs2_data = read_port(rs2_addr);

endmodule

//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t; // B format shares this layout

	typedef struct packed {
		logic [19:0] imm20;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t; // J format shares this layout

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		u_fmt_t u_fmt;
	} inst_word_u;

	localparam logic [6:0] OPC_LUI     = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
	localparam logic [6:0] OPC_JAL     = 7'b1101111;
	localparam logic [6:0] OPC_JALR    = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
	localparam logic [6:0] OPC_LOAD    = 7'b0000011;
	localparam logic [6:0] OPC_STORE   = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
	localparam logic [6:0] OPC_OP      = 7'b0110011;
	localparam logic [6:0] OPC_MISCMEM = 7'b0001111;

	// one-hot class bit positions
	localparam int INST_LUI     = 0;
	localparam int INST_AUIPC   = 1;
	localparam int INST_JAL     = 2;
	localparam int INST_JALR    = 3;
	localparam int INST_BEQ     = 4; // all conditional branches
	localparam int INST_LW      = 5;
	localparam int INST_SW      = 6;
	localparam int INST_ADDI    = 7; // op-imm group
	localparam int INST_ADD     = 8; // op group
	localparam int INST_CLASSES = 9;

endpackage
